// File: hdl/hwpe_cfg_pkg.sv
/*
 * HWPE configuration definitions
 * Register map, controller states, status and performance types,
 * and the Wishbone classic request and response bundles
 */
package hwpe_cfg_pkg;

  localparam int CFG_AW = 6;
  localparam int CFG_DW = 32;
  localparam int PERF_W = 16;

  // Word addresses on the configuration bus
  localparam logic [CFG_AW-1:0] REG_TRIGGER     = 6'd0;
  localparam logic [CFG_AW-1:0] REG_STATUS      = 6'd1;
  localparam logic [CFG_AW-1:0] REG_PERF_CYCLES = 6'd8;
  localparam logic [CFG_AW-1:0] REG_PERF_REQS   = 6'd9;
  localparam logic [CFG_AW-1:0] REG_PERF_STALLS = 6'd10;
  // Stream k base register sits at REG_IO_BASE + k
  localparam logic [CFG_AW-1:0] REG_IO_BASE     = 6'd16;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [CFG_AW-1:0] adr;
    logic [CFG_DW-1:0] dat;
    logic [3:0]        sel;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [CFG_DW-1:0] dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_START,
    CTRL_RUN,
    CTRL_DRAIN,
    CTRL_DONE
  } ctrl_state_e;

  typedef struct packed {
    logic [PERF_W-1:0] cycles;
    logic [PERF_W-1:0] reqs;
    logic [PERF_W-1:0] stalls;
  } perf_t;

endpackage

// File: hdl/hwpe_mem_pkg.sv
/*
 * HWPE memory side definitions
 * TCDM request/grant port and accelerator chip-select/wait port
 */
package hwpe_mem_pkg;

  localparam int MEM_AW = 32;
  localparam int MEM_DW = 32;
  localparam int MEM_BW = 4;

  // TCDM master request, wen high means read
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [MEM_AW-1:0] add;
    logic [MEM_BW-1:0] be;
    logic [MEM_DW-1:0] data;
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [MEM_DW-1:0] r_data;
  } tcdm_rsp_t;

  // Accelerator access, same wen convention as the TCDM
  typedef struct packed {
    logic              cs_n;
    logic              wen;
    logic [MEM_AW-1:0] addr;
    logic [MEM_BW-1:0] be;
    logic [MEM_DW-1:0] wdata;
  } acc_req_t;

  typedef struct packed {
    logic              wait_n;
    logic [MEM_DW-1:0] rdata;
  } acc_rsp_t;

endpackage

// File: hdl/hwpe_cfg_slave.sv
`timescale 1ns/1ps

/*
 * HWPE configuration slave
 * Wishbone classic register file with stream base addresses, job trigger,
 * status with completed-job count and performance counter readback
 */
module hwpe_cfg_slave #(
  parameter int N_IO_REGS = 2
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  hwpe_cfg_pkg::wb_req_t                          wb_i,
  output hwpe_cfg_pkg::wb_rsp_t                          wb_o,
  input  logic                                           busy_i,
  input  logic                                           job_done_i,
  input  hwpe_cfg_pkg::perf_t                            perf_i,
  output logic                                           job_start_o,
  output logic [N_IO_REGS-1:0][hwpe_mem_pkg::MEM_AW-1:0] io_base_o
);
  import hwpe_cfg_pkg::*;

  logic              ack_q;
  logic [CFG_DW-1:0] rdata_q;
  logic [CFG_DW-1:0] rdata_d;
  logic [7:0]        job_cnt_q;
  logic              access;
  logic              wr_access;
  logic [CFG_AW-1:0] base_idx;
  logic              base_hit;

  // New access is a request not yet acknowledged
  assign access    = wb_i.cyc & wb_i.stb & ~ack_q;
  assign wr_access = access & wb_i.we;

  assign base_idx = wb_i.adr - REG_IO_BASE;
  assign base_hit = (wb_i.adr >= REG_IO_BASE) && (base_idx < CFG_AW'(N_IO_REGS));

  // Read mux, unmapped words and the trigger read as zero
  always_comb begin
    rdata_d = '0;
    case (wb_i.adr)
      REG_STATUS:      rdata_d = {16'h0, job_cnt_q, 7'h0, busy_i};
      REG_PERF_CYCLES: rdata_d = CFG_DW'(perf_i.cycles);
      REG_PERF_REQS:   rdata_d = CFG_DW'(perf_i.reqs);
      REG_PERF_STALLS: rdata_d = CFG_DW'(perf_i.stalls);
      default: begin
        for (int k = 0; k < N_IO_REGS; k++) begin
          if (base_hit && (base_idx == CFG_AW'(k))) begin
            rdata_d = CFG_DW'(io_base_o[k]);
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q       <= 1'b0;
      job_start_o <= 1'b0;
      job_cnt_q   <= '0;
    end else begin
      ack_q       <= access;
      // Triggers while a job runs are dropped
      job_start_o <= wr_access && (wb_i.adr == REG_TRIGGER) && !busy_i;
      if (job_done_i) begin
        job_cnt_q <= job_cnt_q + 8'd1;
      end
    end
  end

  // Base registers with byte selects, base and data are both 32 bits wide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_base_o <= '0;
    end else if (wr_access && base_hit) begin
      for (int k = 0; k < N_IO_REGS; k++) begin
        if (base_idx == CFG_AW'(k)) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_i.sel[b]) begin
              io_base_o[k][8*b +: 8] <= wb_i.dat[8*b +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdata_q;

endmodule

// File: hdl/hwpe_ctrl_fsm.sv
`timescale 1ns/1ps

/*
 * HWPE job controller
 * Sequences start, run, drain of outstanding reads and the end-of-job event
 */
module hwpe_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic job_start_i,
  input  logic catc_done_i,
  input  logic stall_i,
  input  logic bridge_idle_i,
  output logic catc_start_o,
  output logic catc_en_o,
  output logic run_o,
  output logic busy_o,
  output logic job_done_o
);
  import hwpe_cfg_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (job_start_i) begin
          state_d = CTRL_START;
        end
      end
      CTRL_START: state_d = CTRL_RUN;
      CTRL_RUN: begin
        if (catc_done_i) begin
          state_d = CTRL_DRAIN;
        end
      end
      // Hold until no read is left in flight
      CTRL_DRAIN: begin
        if (bridge_idle_i) begin
          state_d = CTRL_DONE;
        end
      end
      CTRL_DONE: state_d = CTRL_IDLE;
      default:   state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign catc_start_o = (state_q == CTRL_START);
  assign run_o        = (state_q == CTRL_RUN);
  // Accelerator frozen for every cycle the bridge holds it
  assign catc_en_o    = run_o & ~stall_i;
  assign busy_o       = (state_q != CTRL_IDLE);
  assign job_done_o   = (state_q == CTRL_DONE);

endmodule

// File: hdl/hwpe_perf_counters.sv
`timescale 1ns/1ps

/*
 * HWPE performance counters
 * Saturating busy-cycle, memory request and memory stall counts per job
 */
module hwpe_perf_counters (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear_i,
  input  logic                busy_i,
  input  logic                req_i,
  input  logic                gnt_i,
  output hwpe_cfg_pkg::perf_t perf_o
);
  import hwpe_cfg_pkg::*;

  perf_t perf_q;

  // Increment that sticks at all ones
  function automatic logic [PERF_W-1:0] sat_inc(input logic [PERF_W-1:0] cnt,
                                                input logic              en);
    logic [PERF_W-1:0] res;
    res = cnt;
    if (en && (cnt != '1)) begin
      res = cnt + 1'b1;
    end
    return res;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      perf_q <= '0;
    end else if (clear_i) begin
      perf_q <= '0;
    end else begin
      perf_q.cycles <= sat_inc(perf_q.cycles, busy_i);
      perf_q.reqs   <= sat_inc(perf_q.reqs, req_i);
      // Stall is a request cycle without grant
      perf_q.stalls <= sat_inc(perf_q.stalls, req_i & ~gnt_i);
    end
  end

  assign perf_o = perf_q;

endmodule

// File: hdl/hwpe_port_bridge.sv
`timescale 1ns/1ps

/*
 * HWPE accelerator to TCDM bridge
 * Relocates accelerator accesses by stream base address, holds the
 * accelerator through grant back-pressure and returns read data
 */
module hwpe_port_bridge #(
  parameter int N_IO_REGS = 2,
  parameter int OFFSET_W  = 16
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           run_i,
  input  logic [N_IO_REGS-1:0][hwpe_mem_pkg::MEM_AW-1:0] io_base_i,
  input  hwpe_mem_pkg::acc_req_t                         acc_i,
  output hwpe_mem_pkg::acc_rsp_t                         acc_o,
  output hwpe_mem_pkg::tcdm_req_t                        tcdm_o,
  input  hwpe_mem_pkg::tcdm_rsp_t                        tcdm_i,
  output logic                                           stall_o,
  output logic                                           idle_o
);
  import hwpe_mem_pkg::*;

  localparam int SEL_W = MEM_AW - OFFSET_W;

  typedef enum logic [1:0] {
    BR_FREE,
    BR_WAIT_GNT,
    BR_WAIT_RD
  } br_state_e;

  br_state_e         state;
  logic              pending_q;
  logic              new_req;
  logic              wait_n;
  logic [SEL_W-1:0]  stream_sel;
  logic [MEM_AW-1:0] base;
  logic [MEM_AW-1:0] offset;

  // Upper address bits pick the stream, out-of-range picks stream 0
  assign stream_sel = acc_i.addr[MEM_AW-1:OFFSET_W];
  assign offset     = {{SEL_W{1'b0}}, acc_i.addr[OFFSET_W-1:0]};

  always_comb begin
    base = io_base_i[0];
    for (int k = 1; k < N_IO_REGS; k++) begin
      if (stream_sel == SEL_W'(k)) begin
        base = io_base_i[k];
      end
    end
  end

  // No new request while a read waits for its data
  assign new_req = ~acc_i.cs_n & run_i & ~pending_q;

  always_comb begin
    if (pending_q) begin
      state = BR_WAIT_RD;
    end else if (new_req && !tcdm_i.gnt) begin
      state = BR_WAIT_GNT;
    end else begin
      state = BR_FREE;
    end
  end

  always_comb begin
    case (state)
      BR_WAIT_RD:  wait_n = tcdm_i.r_valid;
      BR_WAIT_GNT: wait_n = 1'b0;
      // Granted writes finish now, granted reads wait a cycle
      default:     wait_n = acc_i.cs_n | (run_i & ~acc_i.wen);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      pending_q <= ~tcdm_i.r_valid;
    end else begin
      pending_q <= new_req & tcdm_i.gnt & acc_i.wen;
    end
  end

  assign tcdm_o.req  = new_req;
  assign tcdm_o.wen  = acc_i.wen;
  assign tcdm_o.add  = base + offset;
  assign tcdm_o.be   = acc_i.be;
  assign tcdm_o.data = acc_i.wdata;

  assign acc_o.wait_n = wait_n;
  assign acc_o.rdata  = tcdm_i.r_data;

  assign stall_o = ~wait_n;
  assign idle_o  = ~pending_q;

endmodule

// File: hdl/hwpe_sm_wrapper.sv
`timescale 1ns/1ps

/*
 * Shared-memory HWPE wrapper top level
 * Couples an HLS accelerator to the TCDM and a Wishbone configuration port
 */
module hwpe_sm_wrapper #(
  parameter int N_IO_REGS = 2,
  parameter int OFFSET_W  = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  hwpe_cfg_pkg::wb_req_t   wb_i,
  output hwpe_cfg_pkg::wb_rsp_t   wb_o,
  output hwpe_mem_pkg::tcdm_req_t tcdm_o,
  input  hwpe_mem_pkg::tcdm_rsp_t tcdm_i,
  input  hwpe_mem_pkg::acc_req_t  acc_i,
  output hwpe_mem_pkg::acc_rsp_t  acc_o,
  output logic                    catc_start_o,
  output logic                    catc_en_o,
  input  logic                    catc_done_i,
  output logic                    evt_interrupt_o
);
  import hwpe_cfg_pkg::*;
  import hwpe_mem_pkg::*;

  logic                             job_start;
  logic [N_IO_REGS-1:0][MEM_AW-1:0] io_base;
  logic                             busy;
  logic                             run;
  logic                             job_done;
  logic                             stall;
  logic                             bridge_idle;
  perf_t                            perf;

  hwpe_cfg_slave #(
    .N_IO_REGS (N_IO_REGS)
  ) u_cfg_slave (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .busy_i      (busy),
    .job_done_i  (job_done),
    .perf_i      (perf),
    .job_start_o (job_start),
    .io_base_o   (io_base)
  );

  hwpe_ctrl_fsm u_ctrl_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .job_start_i   (job_start),
    .catc_done_i   (catc_done_i),
    .stall_i       (stall),
    .bridge_idle_i (bridge_idle),
    .catc_start_o  (catc_start_o),
    .catc_en_o     (catc_en_o),
    .run_o         (run),
    .busy_o        (busy),
    .job_done_o    (job_done)
  );

  hwpe_perf_counters u_perf_counters (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (job_start),
    .busy_i  (busy),
    .req_i   (tcdm_o.req),
    .gnt_i   (tcdm_i.gnt),
    .perf_o  (perf)
  );

  hwpe_port_bridge #(
    .N_IO_REGS (N_IO_REGS),
    .OFFSET_W  (OFFSET_W)
  ) u_port_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_i     (run),
    .io_base_i (io_base),
    .acc_i     (acc_i),
    .acc_o     (acc_o),
    .tcdm_o    (tcdm_o),
    .tcdm_i    (tcdm_i),
    .stall_o   (stall),
    .idle_o    (bridge_idle)
  );

  // End-of-job event
  assign evt_interrupt_o = job_done;

endmodule

// File: verification/tb_hwpe_tasks.svh
/*
 * HWPE wrapper testbench tasks
 * Wishbone host accesses, LFSR, accelerator accesses and directed tests
 */
`ifndef TB_HWPE_TASKS_SVH
`define TB_HWPE_TASKS_SVH

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned lfsr_take(input int unsigned nbits);
    int unsigned val;
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
    return val;
  endfunction

  // Initial memory contents, unique per word
  function automatic logic [MEM_DW-1:0] fill_word(input logic [13:0] idx);
    return {2'b10, idx, 2'b01, ~idx};
  endfunction

  function automatic logic [CFG_DW-1:0] status_word(input logic busy);
    return {16'h0, 8'(jobs_done), 7'h0, busy};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] want,
                          input logic [31:0] got);
    assert (got === want) else begin
      $display("[FAIL] %s expected %h got %h", name, want, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned mark);
    if (errors == mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - mark);
      failed_tests++;
    end
  endtask

  // One Wishbone classic cycle, ack registered by the slave
  task automatic wb_access(input logic we, input logic [CFG_AW-1:0] adr,
                           input logic [CFG_DW-1:0] wdat,
                           output logic [CFG_DW-1:0] rdat);
    int n;
    n = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    wb_req.sel = 4'hf;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!wb_rsp.ack && n < 20);
    if (!wb_rsp.ack) begin
      $display("Error: no Wishbone ack for word address %0d", adr);
      errors++;
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [CFG_AW-1:0] adr, input logic [CFG_DW-1:0] dat);
    logic [CFG_DW-1:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [CFG_AW-1:0] adr, output logic [CFG_DW-1:0] dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic wb_check(input logic [CFG_AW-1:0] adr, input logic [CFG_DW-1:0] want,
                          input string name);
    logic [CFG_DW-1:0] got;
    wb_read(adr, got);
    check_eq(name, want, got);
  endtask

  // Accelerator access held until wait_n is seen high on an edge
  task automatic acc_access(input logic [MEM_AW-1:0] addr, input logic wen,
                            input logic [MEM_BW-1:0] be, input logic [MEM_DW-1:0] wdata,
                            output logic [MEM_DW-1:0] rdata);
    int n;
    n = 0;
    acc_req.cs_n  = 1'b0;
    acc_req.wen   = wen;
    acc_req.addr  = addr;
    acc_req.be    = be;
    acc_req.wdata = wdata;
    do begin
      @(posedge clk);
      n++;
    end while (!acc_rsp.wait_n && n < 100);
    if (!acc_rsp.wait_n) begin
      $display("Error: accelerator access to %h never completed", addr);
      errors++;
    end
    rdata = acc_rsp.rdata;
    #1;
    acc_req.cs_n = 1'b1;
  endtask

  // Trigger a job and wait for the start pulse, leaves the FSM in RUN
  task automatic start_job();
    int n;
    int unsigned s0;
    s0       = start_cnt;
    withheld = 0;
    grants   = 0;
    wb_write(REG_TRIGGER, 32'h1);
    n = 0;
    while (start_cnt == s0 && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (start_cnt == s0) begin
      $display("Error: no catc_start pulse after the trigger write");
      errors++;
    end
  endtask

  task automatic finish_job();
    int n;
    int unsigned e0;
    e0        = evt_cnt;
    catc_done = 1'b1;
    @(posedge clk);
    #1;
    catc_done = 1'b0;
    n = 0;
    while (evt_cnt == e0 && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    repeat (2) @(posedge clk);
    #1;
    check_eq("evt_interrupt pulse count", e0 + 1, evt_cnt);
    jobs_done++;
  endtask

  task automatic test_reset_regs();
    wb_check(REG_STATUS, 32'h0, "STATUS");
    wb_check(REG_PERF_CYCLES, 32'h0, "PERF_CYCLES");
    wb_check(REG_PERF_REQS, 32'h0, "PERF_REQS");
    wb_check(REG_PERF_STALLS, 32'h0, "PERF_STALLS");
    wb_write(REG_IO_BASE, BASE0);
    wb_write(REG_IO_BASE + 6'd1, BASE1);
    wb_check(REG_IO_BASE, BASE0, "IO_BASE0");
    wb_check(REG_IO_BASE + 6'd1, BASE1, "IO_BASE1");
    // Read-only and unmapped words
    wb_write(REG_STATUS, 32'hffff_ffff);
    wb_check(REG_STATUS, status_word(1'b0), "STATUS");
    wb_check(6'd5, 32'h0, "unmapped word 5");
    wb_check(REG_IO_BASE + 6'd2, 32'h0, "unmapped IO_BASE2");
  endtask

  task automatic test_job_event();
    int unsigned s0;
    s0 = start_cnt;
    start_job();
    wb_check(REG_STATUS, status_word(1'b1), "STATUS");
    finish_job();
    check_eq("catc_start pulse count", s0 + 1, start_cnt);
    wb_check(REG_STATUS, status_word(1'b0), "STATUS");
  endtask

  task automatic test_stream_writes();
    logic [MEM_AW-1:0] addr [5];
    logic [MEM_AW-1:0] phys [5];
    logic [MEM_BW-1:0] be [5];
    logic [MEM_DW-1:0] data [5];
    logic [MEM_DW-1:0] want;
    logic [MEM_DW-1:0] unused;
    addr = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0040, 32'h0001_0008, 32'h0001_0100};
    phys = '{BASE0, BASE0 + 32'h4, BASE0 + 32'h40, BASE1 + 32'h8, BASE1 + 32'h100};
    be   = '{4'hf, 4'h3, 4'hc, 4'hf, 4'h5};
    data = '{32'h1111_2222, 32'h3344_5566, 32'h7788_99aa, 32'hbbcc_ddee, 32'h0f1e_2d3c};
    start_job();
    foreach (addr[i]) begin
      acc_access(addr[i], 1'b0, be[i], data[i], unused);
    end
    finish_job();
    foreach (addr[i]) begin
      want = fill_word(phys[i][15:2]);
      for (int b = 0; b < MEM_BW; b++) begin
        if (be[i][b]) begin
          want[8*b +: 8] = data[i][8*b +: 8];
        end
      end
      check_eq("memory word", want, mem[phys[i][15:2]]);
    end
  endtask

  task automatic test_stream_reads();
    logic [MEM_AW-1:0] addr [5];
    logic [MEM_AW-1:0] phys [5];
    logic [MEM_DW-1:0] rdata;
    // Stream selects 2 and 0xff fall back to stream 0
    addr = '{32'h0000_0010, 32'h0000_0080, 32'h0001_0020, 32'h0002_0014, 32'h00ff_0018};
    phys = '{BASE0 + 32'h10, BASE0 + 32'h80, BASE1 + 32'h20, BASE0 + 32'h14,
             BASE0 + 32'h18};
    start_job();
    foreach (addr[i]) begin
      acc_access(addr[i], 1'b1, 4'hf, '0, rdata);
      check_eq("acc_rsp.rdata", fill_word(phys[i][15:2]), rdata);
    end
    finish_job();
  endtask

  task automatic test_backpressure();
    logic [MEM_DW-1:0] rdata;
    logic [CFG_DW-1:0] cycles;
    logic [MEM_AW-1:0] off;
    start_job();
    for (int i = 0; i < 12; i++) begin
      off = 32'h200 + 4 * i;
      if (i % 2 == 1) begin
        acc_access(32'h0001_0000 + off, 1'b1, 4'hf, '0, rdata);
        check_eq("acc_rsp.rdata", fill_word(BASE1[15:2] + off[15:2]), rdata);
      end else begin
        acc_access(off, 1'b0, 4'hf, 32'hc0de_0000 + i, rdata);
      end
    end
    finish_job();
    assert (withheld > 0) else begin
      $display("Error: the memory model never withheld a grant");
      errors++;
    end
    wb_check(REG_PERF_STALLS, withheld, "PERF_STALLS");
    wb_check(REG_PERF_REQS, withheld + grants, "PERF_REQS");
    wb_read(REG_PERF_CYCLES, cycles);
    assert (cycles >= withheld + grants) else begin
      $display("[FAIL] PERF_CYCLES expected at least %h got %h", withheld + grants, cycles);
      errors++;
    end
  endtask

  task automatic test_retrigger();
    logic [CFG_DW-1:0] prev_cycles;
    logic [CFG_DW-1:0] cycles;
    logic [MEM_DW-1:0] rdata;
    int unsigned       s0;
    s0 = start_cnt;
    start_job();
    acc_access(32'h0000_0400, 1'b0, 4'hf, 32'h1234_5678, rdata);
    // Second trigger while busy must be dropped
    wb_write(REG_TRIGGER, 32'h1);
    repeat (4) @(posedge clk);
    #1;
    acc_access(32'h0001_0400, 1'b1, 4'hf, '0, rdata);
    finish_job();
    check_eq("catc_start pulse count", s0 + 1, start_cnt);
    wb_check(REG_STATUS, status_word(1'b0), "STATUS");
    wb_read(REG_PERF_CYCLES, prev_cycles);
    start_job();
    wb_check(REG_PERF_REQS, 32'h0, "PERF_REQS");
    wb_check(REG_PERF_STALLS, 32'h0, "PERF_STALLS");
    wb_read(REG_PERF_CYCLES, cycles);
    assert (cycles < prev_cycles) else begin
      $display("[FAIL] PERF_CYCLES expected below %h got %h", prev_cycles, cycles);
      errors++;
    end
    acc_access(32'h0000_0408, 1'b0, 4'hf, 32'h8765_4321, rdata);
    finish_job();
    wb_check(REG_STATUS, status_word(1'b0), "STATUS");
  endtask

`endif

// File: verification/tb_hwpe_sm_wrapper.sv
`timescale 1ns/1ps

/*
 * Testbench for the shared-memory HWPE wrapper
 * Wishbone host, TCDM model with random grant delay, accelerator model
 */
module tb_hwpe_sm_wrapper;
  import hwpe_cfg_pkg::*;
  import hwpe_mem_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_TESTS    = 6;
  localparam int MEM_WORDS  = 16384;
  localparam logic [MEM_AW-1:0] BASE0 = 32'h0000_1000;
  localparam logic [MEM_AW-1:0] BASE1 = 32'h0000_4000;

  logic      clk;
  logic      rst_n;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  tcdm_req_t tcdm_req;
  tcdm_rsp_t tcdm_rsp;
  acc_req_t  acc_req;
  acc_rsp_t  acc_rsp;
  logic      catc_start;
  logic      catc_en;
  logic      catc_done;
  logic      evt_irq;

  logic [MEM_DW-1:0] mem [MEM_WORDS];
  logic [31:0]       lfsr_state;
  int unsigned       hold_left;
  int unsigned       withheld;
  int unsigned       grants;
  logic              rd_now;
  logic [MEM_DW-1:0] rd_word;
  logic              in_run;
  int unsigned       start_cnt;
  int unsigned       evt_cnt;
  int unsigned       jobs_done;
  int unsigned       errors;
  int unsigned       failed_tests;
  int unsigned       err_mark;

  hwpe_sm_wrapper #(
    .N_IO_REGS (2),
    .OFFSET_W  (16)
  ) dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_i            (wb_req),
    .wb_o            (wb_rsp),
    .tcdm_o          (tcdm_req),
    .tcdm_i          (tcdm_rsp),
    .acc_i           (acc_req),
    .acc_o           (acc_rsp),
    .catc_start_o    (catc_start),
    .catc_en_o       (catc_en),
    .catc_done_i     (catc_done),
    .evt_interrupt_o (evt_irq)
  );

  `include "tb_hwpe_tasks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  // TCDM model sampled on the edge and driven 1 ns later
  always @(posedge clk) begin
    rd_now = 1'b0;
    if (rst_n && tcdm_req.req) begin
      // Model covers the low 64 KiB only
      assert (tcdm_req.add[MEM_AW-1:16] == '0) else begin
        $display("Error: memory request to %h lies outside the memory model", tcdm_req.add);
        errors++;
      end
      if (tcdm_rsp.gnt) begin
        grants++;
        if (tcdm_req.wen) begin
          rd_now  = 1'b1;
          rd_word = mem[tcdm_req.add[15:2]];
        end else begin
          for (int b = 0; b < MEM_BW; b++) begin
            if (tcdm_req.be[b]) begin
              mem[tcdm_req.add[15:2]][8*b +: 8] = tcdm_req.data[8*b +: 8];
            end
          end
        end
        // Grant delay of 0 to 3 cycles for the next request
        hold_left = lfsr_take(2);
      end else begin
        withheld++;
        hold_left--;
      end
    end
    #1;
    tcdm_rsp.gnt     = (hold_left == 0);
    tcdm_rsp.r_valid = rd_now;
    tcdm_rsp.r_data  = rd_now ? rd_word : '0;
  end

  // Pulse counters and accelerator enable checks
  always @(posedge clk) begin
    if (rst_n) begin
      if (catc_start) begin
        start_cnt++;
      end
      if (evt_irq) begin
        evt_cnt++;
      end
      if (in_run) begin
        assert (catc_en === acc_rsp.wait_n) else begin
          $display("[FAIL] catc_en expected %h got %h at %0t ns", acc_rsp.wait_n, catc_en,
                   $time);
          errors++;
        end
      end else begin
        assert (catc_en === 1'b0) else begin
          $display("[FAIL] catc_en expected %h got %h at %0t ns", 1'b0, catc_en, $time);
          errors++;
        end
      end
      // RUN follows the start cycle and ends on the done cycle
      if (catc_start) begin
        in_run = 1'b1;
      end
      if (catc_done) begin
        in_run = 1'b0;
      end
    end
  end

  initial begin
    #(N_TESTS * 2000 * CLK_PERIOD);
    $display("Error: watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    wb_req       = '0;
    acc_req      = '0;
    acc_req.cs_n = 1'b1;
    catc_done    = 1'b0;
    tcdm_rsp     = '0;
    tcdm_rsp.gnt = 1'b1;
    lfsr_state   = 32'hb9ba;
    hold_left    = 0;
    withheld     = 0;
    grants       = 0;
    in_run       = 1'b0;
    start_cnt    = 0;
    evt_cnt      = 0;
    jobs_done    = 0;
    errors       = 0;
    failed_tests = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(14'(i));
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err_mark = errors;
    test_reset_regs();
    report_test("reset_regs", err_mark);
    err_mark = errors;
    test_job_event();
    report_test("job_event", err_mark);
    err_mark = errors;
    test_stream_writes();
    report_test("stream_writes", err_mark);
    err_mark = errors;
    test_stream_reads();
    report_test("stream_reads", err_mark);
    err_mark = errors;
    test_backpressure();
    report_test("backpressure", err_mark);
    err_mark = errors;
    test_retrigger();
    report_test("retrigger", err_mark);

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             N_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verification
hdl/hwpe_cfg_pkg.sv
hdl/hwpe_mem_pkg.sv
hdl/hwpe_cfg_slave.sv
hdl/hwpe_ctrl_fsm.sv
hdl/hwpe_perf_counters.sv
hdl/hwpe_port_bridge.sv
hdl/hwpe_sm_wrapper.sv
verification/tb_hwpe_sm_wrapper.sv
